//--- logic/spi_master_pkg.sv
package spi_master_pkg;

	//////////////////////////////////////////////////////////////////////
	// Clocking and bus timing
	//////////////////////////////////////////////////////////////////////
	localparam int spi_clk_ratio  = 8;                      // System clocks per SPI bit
	localparam int quarter_cycles = spi_clk_ratio / 4;      // Clocks between quarter strobes
	localparam int phase_cnt_w    = $clog2(spi_clk_ratio);  // Phase counter width
	localparam int guard_bits     = 4;                      // Chip-select guard, in bits
	localparam int timer_max      = (256 + 6) * 8;          // Longest state, in bits

	// FIFO geometry with a power-of-two depth
	localparam int fifo_depth  = 16;
	localparam int fifo_addr_w = $clog2(fifo_depth);

	typedef logic [7:0]  byte_t;
	typedef logic [8:0]  len_t;    // Up to 256+6 bytes
	typedef logic [9:0]  wait_t;   // Up to 512 bit periods
	typedef logic [11:0] timer_t;  // Reaches (256+6)*8

	// Bus states in Gray order
	typedef enum logic [2:0] {
		IDLE    = 3'b000,
		START_D = 3'b001,  // csn high guard
		START_S = 3'b011,  // csn low guard
		TX      = 3'b010,
		WAIT    = 3'b110,  // Dummy cycles
		RX      = 3'b111,
		STOP_S  = 3'b101,  // csn low guard
		STOP_D  = 3'b100   // csn high guard
	} spi_state_t;

	// One transaction request
	typedef struct packed {
		len_t  tx_len;
		len_t  rx_len;
		wait_t wait_cyc;
	} spi_cmd_t;

	// Quarter-period strobes and sck level
	typedef struct packed {
		logic quarter;  // Every quarter period
		logic ce0;      // sck rise point
		logic ce2;      // sck fall point and state step
		logic ce3;      // Receive capture point
		logic sck;
	} spi_phase_t;

	typedef struct packed {
		logic sck;
		logic csn;
		logic copi;
	} spi_pins_t;

endpackage

//--- logic/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo (
	input  logic                  i_ext_spi_clk_x,
	input  logic                  i_srst,
	input  logic                  wr_en_i,
	input  spi_master_pkg::byte_t wr_data_i,
	input  logic                  rd_en_i,
	output spi_master_pkg::byte_t rd_data_o,
	output logic                  full_o,
	output logic                  empty_o
);
	import spi_master_pkg::*;

	byte_t                  mem [fifo_depth];  // Circular buffer
	logic [fifo_addr_w-1:0] wr_ptr_q;
	logic [fifo_addr_w-1:0] rd_ptr_q;
	logic [fifo_addr_w:0]   count_q;           // One extra bit for full
	logic                   do_wr;
	logic                   do_rd;

	assign full_o  = (count_q == (fifo_addr_w + 1)'(fifo_depth));
	assign empty_o = (count_q == '0);

	assign do_wr = wr_en_i && !full_o;  // Drop writes when full
	assign do_rd = rd_en_i && !empty_o; // Drop reads when empty

	// Pointers and fill level
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;

			case ({do_wr, do_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // Both or neither
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (do_wr)
			mem[wr_ptr_q] <= wr_data_i;
		if (do_rd)
			rd_data_o <= mem[rd_ptr_q];  // Holds last byte between reads
	end

endmodule

//--- logic/spi_phase_gen.sv
`timescale 1ns/1ns

module spi_phase_gen (
	input  logic                       i_ext_spi_clk_x,
	input  logic                       i_srst,
	output spi_master_pkg::spi_phase_t phase_o
);
	import spi_master_pkg::*;

	logic [phase_cnt_w-1:0] cnt_q;  // Position within the bit period
	logic                   sck_q;
	logic                   ce0;
	logic                   ce2;

	// Bit period counter
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst)
			cnt_q <= '0;
		else if (cnt_q == phase_cnt_w'(spi_clk_ratio - 1))
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1;
	end

	assign ce0 = (cnt_q == '0);                                // Start of period
	assign ce2 = (cnt_q == phase_cnt_w'(2 * quarter_cycles));  // Half way

	// sck high over the first half of the period
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst)
			sck_q <= 1'b0;
		else if (ce0)
			sck_q <= 1'b1;
		else if (ce2)
			sck_q <= 1'b0;
	end

	assign phase_o.quarter = ((cnt_q % quarter_cycles) == 0);
	assign phase_o.ce0     = ce0;
	assign phase_o.ce2     = ce2;
	assign phase_o.ce3     = (cnt_q == phase_cnt_w'(3 * quarter_cycles));
	assign phase_o.sck     = sck_q;

endmodule

//--- logic/spi_cmd_capture.sv
`timescale 1ns/1ns

module spi_cmd_capture (
	input  logic                     i_ext_spi_clk_x,
	input  logic                     i_srst,
	input  logic                     go_i,
	input  spi_master_pkg::spi_cmd_t cmd_i,
	output spi_master_pkg::spi_cmd_t cmd_o,
	output logic                     go_hold_o,
	output logic                     waiting_o
);
	import spi_master_pkg::*;

	// One hold state per quarter period
	typedef enum logic [2:0] {
		PULSE_WAIT,
		PULSE_HOLD_0,
		PULSE_HOLD_1,
		PULSE_HOLD_2,
		PULSE_HOLD_3
	} pulse_state_t;

	pulse_state_t           state_q;
	logic [phase_cnt_w-1:0] qcnt_q;    // Clocks within one quarter
	logic                   qtick;     // Last clock of a quarter
	logic                   go_hold_q;
	spi_cmd_t               cmd_q;

	assign qtick = (qcnt_q == phase_cnt_w'(quarter_cycles - 1));

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			state_q   <= PULSE_WAIT;
			qcnt_q    <= '0;
			go_hold_q <= 1'b0;
		end else begin
			case (state_q)
				PULSE_WAIT: begin
					qcnt_q <= '0;
					if (go_i) begin
						state_q   <= PULSE_HOLD_0;  // Start stretching go
						go_hold_q <= 1'b1;
					end
				end
				default: begin
					if (qtick) begin
						qcnt_q <= '0;
						case (state_q)
							PULSE_HOLD_0: state_q <= PULSE_HOLD_1;
							PULSE_HOLD_1: state_q <= PULSE_HOLD_2;
							PULSE_HOLD_2: state_q <= PULSE_HOLD_3;
							default: begin
								state_q   <= PULSE_WAIT;  // Full bit period covered
								go_hold_q <= 1'b0;
							end
						endcase
					end else begin
						qcnt_q <= qcnt_q + 1'b1;
					end
				end
			endcase
		end
	end

	// Command is latched only when accepted
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (state_q == PULSE_WAIT && go_i)
			cmd_q <= cmd_i;
	end

	assign cmd_o     = cmd_q;
	assign go_hold_o = go_hold_q;
	assign waiting_o = (state_q == PULSE_WAIT);

endmodule

//--- logic/spi_bus_fsm.sv
`timescale 1ns/1ns

module spi_bus_fsm (
	input  logic                       i_ext_spi_clk_x,
	input  logic                       i_srst,
	input  spi_master_pkg::spi_phase_t phase_i,
	input  logic                       go_hold_i,
	input  spi_master_pkg::spi_cmd_t   cmd_i,
	input  spi_master_pkg::byte_t      tx_byte_i,
	input  logic                       tx_empty_i,
	output logic                       tx_rd_o,
	output spi_master_pkg::spi_state_t state_o,
	output spi_master_pkg::timer_t     timer_o,
	output logic                       fsm_idle_o,
	output spi_master_pkg::spi_pins_t  pins_o
);
	import spi_master_pkg::*;

	spi_state_t state_q;
	spi_state_t state_nx;
	timer_t     timer_q;      // Bits spent in current state
	timer_t     guard_last;
	timer_t     tx_bits;
	timer_t     tx_last;
	timer_t     wait_last;
	timer_t     rx_last;
	spi_pins_t  pins_q;
	logic       sck_run;      // States that clock the bus
	logic       tx_bit;

	//////////////////////////////////////////////////////////////////////
	// Bit counts taken from the held command
	//////////////////////////////////////////////////////////////////////
	assign guard_last = timer_t'(guard_bits - 1);
	assign tx_bits    = {cmd_i.tx_len, 3'b000};            // Eight bits per byte
	assign tx_last    = tx_bits - 1'b1;
	assign wait_last  = timer_t'(cmd_i.wait_cyc) - 1'b1;
	assign rx_last    = {cmd_i.rx_len, 3'b000} - 1'b1;

	// Next state is taken only on the fall strobe
	always_comb begin
		state_nx = state_q;
		case (state_q)
			IDLE:
				if (go_hold_i)
					state_nx = START_D;
			START_D:
				if (timer_q == guard_last)
					state_nx = START_S;
			START_S:
				if (timer_q == guard_last)
					state_nx = TX;
			TX: begin
				if (timer_q == tx_last) begin
					if (cmd_i.rx_len == '0)
						state_nx = STOP_S;  // Write only
					else if (cmd_i.wait_cyc != '0)
						state_nx = WAIT;
					else
						state_nx = RX;      // No dummy cycles
				end
			end
			WAIT:
				if (timer_q == wait_last)
					state_nx = RX;
			RX:
				if (timer_q == rx_last)
					state_nx = STOP_S;
			STOP_S:
				if (timer_q == guard_last)
					state_nx = STOP_D;
			STOP_D:
				if (timer_q == guard_last)
					state_nx = IDLE;
			default:
				state_nx = IDLE;
		endcase
	end

	// State and bit timer step at sck fall
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			state_q <= IDLE;
			timer_q <= '0;
		end else if (phase_i.ce2) begin
			state_q <= state_nx;
			if (state_nx != state_q)
				timer_q <= '0;               // Restart on every change
			else if (timer_q < timer_t'(timer_max))
				timer_q <= timer_q + 1'b1;   // Saturates
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transmit FIFO reads
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		tx_rd_o = 1'b0;
		if (!tx_empty_i) begin
			if (state_q == START_S && timer_q == guard_last)
				tx_rd_o = phase_i.ce3;       // First byte before TX
			else if (state_q == TX && timer_q[2:0] == 3'd7 && timer_q != tx_last)
				tx_rd_o = phase_i.ce2;       // Next byte after bit seven
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered bus pins
	//////////////////////////////////////////////////////////////////////
	assign sck_run = (state_q inside {TX, WAIT, RX});
	assign tx_bit  = (state_q == TX && timer_q < tx_bits) ?
		tx_byte_i[3'd7 - timer_q[2:0]] : 1'b0;  // MSB first

	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			pins_q.sck  <= 1'b0;   // Mode 0 idle level
			pins_q.csn  <= 1'b1;
			pins_q.copi <= 1'b0;
		end else begin
			pins_q.sck  <= phase_i.sck && sck_run;
			pins_q.csn  <= (state_q inside {IDLE, START_D, STOP_D});
			pins_q.copi <= tx_bit;
		end
	end

	assign pins_o     = pins_q;
	assign state_o    = state_q;
	assign timer_o    = timer_q;
	assign fsm_idle_o = (state_q == IDLE);

endmodule

//--- logic/spi_rx_capture.sv
`timescale 1ns/1ns

module spi_rx_capture (
	input  logic                       i_ext_spi_clk_x,
	input  logic                       i_srst,
	input  spi_master_pkg::spi_phase_t phase_i,
	input  spi_master_pkg::spi_state_t state_i,
	input  spi_master_pkg::timer_t     timer_i,
	input  spi_master_pkg::len_t       rx_len_i,
	input  logic                       cipo_i,
	input  logic                       rx_full_i,
	output logic                       wr_en_o,
	output spi_master_pkg::byte_t      wr_data_o
);
	import spi_master_pkg::*;

	spi_state_t state_d1_q;
	spi_state_t state_d2_q;
	spi_state_t state_d3_q;  // Matches sck rise seen back at cipo
	timer_t     timer_d1_q;
	timer_t     timer_d2_q;
	timer_t     timer_d3_q;
	timer_t     rx_bits;
	logic       cipo_meta_q;
	logic       cipo_sync_q;
	logic       sample;
	byte_t      shift_q;
	logic       wr_en_q;

	assign rx_bits = {rx_len_i, 3'b000};
	assign sample  = phase_i.ce3 && (state_d3_q == RX);

	// Three quarter-period delay of state and timer
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst) begin
			state_d1_q <= IDLE;
			state_d2_q <= IDLE;
			state_d3_q <= IDLE;
			timer_d1_q <= '0;
			timer_d2_q <= '0;
			timer_d3_q <= '0;
		end else if (phase_i.quarter) begin
			state_d1_q <= state_i;
			state_d2_q <= state_d1_q;
			state_d3_q <= state_d2_q;
			timer_d1_q <= timer_i;
			timer_d2_q <= timer_d1_q;
			timer_d3_q <= timer_d2_q;
		end
	end

	// Two-flop cipo synchronizer
	always_ff @(posedge i_ext_spi_clk_x) begin
		cipo_meta_q <= cipo_i;
		cipo_sync_q <= cipo_meta_q;
	end

	// Shift in MSB first
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (sample)
			shift_q <= (timer_d3_q < rx_bits) ? {shift_q[6:0], cipo_sync_q} : '0;
	end

	// One write per eighth bit unless the FIFO is full
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst)
			wr_en_q <= 1'b0;
		else
			wr_en_q <= sample && (timer_d3_q[2:0] == 3'd7) && !rx_full_i;
	end

	assign wr_en_o   = wr_en_q;
	assign wr_data_o = shift_q;

endmodule

//--- logic/spi_master_top.sv
`timescale 1ns/1ns

module spi_master_top (
	input  logic                      i_ext_spi_clk_x,
	input  logic                      i_srst,
	input  spi_master_pkg::spi_cmd_t  cmd_i,
	input  logic                      go_i,
	input  spi_master_pkg::byte_t     tx_data_i,
	input  logic                      tx_enqueue_i,
	output logic                      tx_ready_o,
	input  logic                      rx_dequeue_i,
	output spi_master_pkg::byte_t     rx_data_o,
	output logic                      rx_valid_o,
	output logic                      rx_avail_o,
	output logic                      idle_o,
	output spi_master_pkg::spi_pins_t pins_o,
	input  logic                      cipo_i
);
	import spi_master_pkg::*;

	spi_phase_t phase;
	spi_cmd_t   cmd;        // Held copy of the request
	logic       go_hold;
	logic       waiting;
	logic       fsm_idle;
	spi_state_t state;
	timer_t     timer;
	byte_t      tx_byte;
	logic       tx_rd;
	logic       tx_empty;
	logic       tx_full;
	logic       rx_wr;
	byte_t      rx_wr_data;
	logic       rx_full;
	logic       rx_empty;
	logic       rx_rd;
	logic       rx_valid_q;

	//////////////////////////////////////////////////////////////////////
	// System side
	//////////////////////////////////////////////////////////////////////
	assign idle_o     = waiting && fsm_idle;  // Idle only once go is fully absorbed
	assign tx_ready_o = !tx_full;
	assign rx_avail_o = !rx_empty;
	assign rx_rd      = rx_dequeue_i && !rx_empty;
	assign rx_valid_o = rx_valid_q;

	// Read data lands one cycle after the dequeue
	always_ff @(posedge i_ext_spi_clk_x) begin
		if (i_srst)
			rx_valid_q <= 1'b0;
		else
			rx_valid_q <= rx_rd;
	end

	spi_phase_gen u_phase (
		.i_ext_spi_clk_x, .i_srst, .phase_o(phase)
	);

	spi_cmd_capture u_cmd (
		.i_ext_spi_clk_x, .i_srst, .go_i, .cmd_i,
		.cmd_o(cmd), .go_hold_o(go_hold), .waiting_o(waiting)
	);

	spi_bus_fsm u_fsm (
		.i_ext_spi_clk_x, .i_srst, .phase_i(phase), .go_hold_i(go_hold), .cmd_i(cmd),
		.tx_byte_i(tx_byte), .tx_empty_i(tx_empty), .tx_rd_o(tx_rd),
		.state_o(state), .timer_o(timer), .fsm_idle_o(fsm_idle), .pins_o
	);

	spi_rx_capture u_rx (
		.i_ext_spi_clk_x, .i_srst, .phase_i(phase), .state_i(state), .timer_i(timer),
		.rx_len_i(cmd.rx_len), .cipo_i, .rx_full_i(rx_full),
		.wr_en_o(rx_wr), .wr_data_o(rx_wr_data)
	);

	sync_fifo u_fifo_tx (
		.i_ext_spi_clk_x, .i_srst, .wr_en_i(tx_enqueue_i), .wr_data_i(tx_data_i),
		.rd_en_i(tx_rd), .rd_data_o(tx_byte), .full_o(tx_full), .empty_o(tx_empty)
	);

	sync_fifo u_fifo_rx (
		.i_ext_spi_clk_x, .i_srst, .wr_en_i(rx_wr), .wr_data_i(rx_wr_data),
		.rd_en_i(rx_rd), .rd_data_o(rx_data_o), .full_o(rx_full), .empty_o(rx_empty)
	);

endmodule

//--- verif/spi_flash_model.sv
`timescale 1ns/1ns

module spi_flash_model (
	input  spi_master_pkg::spi_pins_t pins_i,
	input  spi_master_pkg::spi_cmd_t  cmd_i,
	output logic                      cipo_o
);
	import spi_master_pkg::*;

	byte_t rx_mem  [32];  // Read data loaded by the testbench
	byte_t rec_mem [32];  // Bytes seen on copi
	int    rec_cnt;       // Bytes recorded in this frame
	int    bit_cnt;       // Rising sck edges in this frame
	int    tx_edges;      // Edges that carry command bytes
	int    rd_base;       // First edge after the dummy cycles
	byte_t shift;
	logic  sck;
	logic  csn;

	assign sck      = pins_i.sck;
	assign csn      = pins_i.csn;
	assign tx_edges = 8 * int'(cmd_i.tx_len);
	assign rd_base  = tx_edges + int'(cmd_i.wait_cyc);

	initial begin
		cipo_o  = 1'b0;
		rec_cnt = 0;
		bit_cnt = 0;
		for (int i = 0; i < 32; i++)
			rx_mem[i] = byte_t'(i) ^ 8'h5a;  // Address pattern until loaded
	end

	// Chip select low opens a new frame
	always @(negedge csn) begin
		bit_cnt = 0;
		rec_cnt = 0;
	end

	// copi is stable at rising sck and arrives MSB first
	always @(posedge sck) begin
		if (!csn) begin
			if (bit_cnt < tx_edges) begin
				shift = {shift[6:0], pins_i.copi};
				if (bit_cnt % 8 == 7 && rec_cnt < 32) begin
					rec_mem[rec_cnt] = shift;  // Whole byte seen
					rec_cnt = rec_cnt + 1;
				end
			end
			bit_cnt = bit_cnt + 1;
		end
	end

	// Next read bit goes out on falling sck
	always @(negedge sck) begin : drive_bit
		int idx;
		if (!csn && bit_cnt >= rd_base) begin
			idx = bit_cnt - rd_base;
			if (idx < 256)
				cipo_o <= rx_mem[idx / 8][7 - idx % 8];
		end
	end

endmodule

//--- verif/tb_spi_master.sv
`timescale 1ns/1ns

module tb_spi_master;
	import spi_master_pkg::*;

	// Bit periods per test including 16 guard bits
	localparam int test_bits = (24 + 16) + (8 + 8 + 32 + 16) + (16 + 16 + 16)
		+ (128 + 16) + (8 + 160 + 16);
	localparam int cycle_limit = test_bits * spi_clk_ratio + 2000;  // Margin for FIFO traffic

	logic        i_ext_spi_clk_x = 1'b0;
	logic        i_srst;
	spi_cmd_t    cmd;
	logic        go;
	byte_t       tx_data;
	logic        tx_enqueue;
	logic        tx_ready;
	logic        rx_dequeue;
	byte_t       rx_data;
	logic        rx_valid;
	logic        rx_avail;
	logic        idle;
	spi_pins_t   pins;
	logic        cipo;

	logic [31:0] lfsr_q    = 32'hff89cf9b;
	byte_t       tx_exp [16];          // Bytes queued for the current transfer
	int          n_checks  = 0;
	int          byte_errs = 0;
	int          bit_errs  = 0;
	int          cycles    = 0;

	always #4 i_ext_spi_clk_x = ~i_ext_spi_clk_x;  // 8 ns period

	spi_master_top dut0 (
		.i_ext_spi_clk_x, .i_srst, .cmd_i(cmd), .go_i(go),
		.tx_data_i(tx_data), .tx_enqueue_i(tx_enqueue), .tx_ready_o(tx_ready),
		.rx_dequeue_i(rx_dequeue), .rx_data_o(rx_data), .rx_valid_o(rx_valid),
		.rx_avail_o(rx_avail), .idle_o(idle), .pins_o(pins), .cipo_i(cipo)
	);

	spi_flash_model flash0 (.pins_i(pins), .cmd_i(cmd), .cipo_o(cipo));

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
	endfunction

	task automatic random_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			b = {b[6:0], lfsr_q[0]};  // One step per bit
		end
	endtask

	task automatic next_cycle();
		@(posedge i_ext_spi_clk_x);
		#1;  // Drive and sample clear of the edge
	endtask

	task automatic check_byte(input byte_t got, input byte_t want, input string what);
		n_checks++;
		if (got !== want) begin
			byte_errs++;
			$display("error @%0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		n_checks++;
		if (got !== want) begin
			bit_errs++;
			$display("error @%0t ns: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// Fill the transmit FIFO from empty so the full flag rises on the last slot
	task automatic load_tx(input int n);
		byte_t b;
		for (int i = 0; i < n; i++) begin
			random_byte(b);
			tx_exp[i]  = b;
			tx_data    = b;
			tx_enqueue = 1'b1;
			next_cycle();
			tx_enqueue = 1'b0;
			check_bit(tx_ready, i < fifo_depth - 1, "tx_ready_o while filling");
		end
	endtask

	task automatic preset_rx(input int n);
		byte_t b;
		for (int i = 0; i < n; i++) begin
			random_byte(b);
			flash0.rx_mem[i] = b;
		end
	endtask

	// One go strobe and a wait for the bus to finish
	task automatic run_transfer(input int n_tx, input int n_wait, input int n_rx);
		cmd.tx_len   = len_t'(n_tx);
		cmd.rx_len   = len_t'(n_rx);
		cmd.wait_cyc = wait_t'(n_wait);
		go = 1'b1;
		next_cycle();
		go = 1'b0;
		check_bit(idle, 1'b0, "idle_o after go");
		while (!idle)
			next_cycle();
		check_bit(pins.csn, 1'b1, "csn at end of transfer");
	endtask

	task automatic check_sent(input int n);
		check_byte(byte_t'(flash0.rec_cnt), byte_t'(n), "bytes seen by flash");
		for (int i = 0; i < n; i++)
			check_byte(flash0.rec_mem[i], tx_exp[i], "copi byte");
	endtask

	task automatic dequeue_check(input byte_t want);
		rx_dequeue = 1'b1;
		next_cycle();
		rx_dequeue = 1'b0;
		check_bit(rx_valid, 1'b1, "rx_valid_o after dequeue");
		check_byte(rx_data, want, "rx_data_o");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_reset();
		check_bit(pins.csn, 1'b1, "csn after reset");
		check_bit(pins.sck, 1'b0, "sck after reset");
		check_bit(pins.copi, 1'b0, "copi after reset");
		check_bit(idle, 1'b1, "idle_o after reset");
		check_bit(rx_avail, 1'b0, "rx_avail_o after reset");
		check_bit(rx_valid, 1'b0, "rx_valid_o after reset");
		check_bit(tx_ready, 1'b1, "tx_ready_o after reset");
	endtask

	task automatic test_write_only();
		load_tx(3);
		run_transfer(3, 0, 0);
		check_sent(3);
		check_bit(rx_avail, 1'b0, "rx_avail_o after write only");
	endtask

	task automatic test_write_wait_read();
		load_tx(1);
		preset_rx(4);
		run_transfer(1, 8, 4);
		check_sent(1);
		check_bit(rx_valid, 1'b0, "rx_valid_o before dequeue");
		for (int i = 0; i < 4; i++)
			dequeue_check(flash0.rx_mem[i]);
		check_bit(rx_avail, 1'b0, "rx_avail_o after drain");
	endtask

	task automatic test_read_no_wait();
		load_tx(2);
		preset_rx(2);
		run_transfer(2, 0, 2);
		check_sent(2);
		for (int i = 0; i < 2; i++)
			dequeue_check(flash0.rx_mem[i]);
	endtask

	task automatic test_fifo_limits();
		load_tx(fifo_depth);  // Ends with tx_ready_o low
		run_transfer(fifo_depth, 0, 0);
		check_sent(fifo_depth);
		load_tx(1);
		preset_rx(20);
		run_transfer(1, 0, 20);  // Last four bytes find the FIFO full
		check_sent(1);
		for (int i = 0; i < fifo_depth; i++) begin
			dequeue_check(flash0.rx_mem[i]);
			check_bit(rx_avail, i < fifo_depth - 1, "rx_avail_o while draining");
		end
	endtask

	// Run limit
	always @(posedge i_ext_spi_clk_x) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		i_srst     = 1'b1;
		cmd        = '0;
		go         = 1'b0;
		tx_data    = '0;
		tx_enqueue = 1'b0;
		rx_dequeue = 1'b0;
		repeat (3)
			next_cycle();
		i_srst = 1'b0;
		next_cycle();

		test_reset();
		test_write_only();
		test_write_wait_read();
		test_read_no_wait();
		test_fifo_limits();

		$display("checks %0d, byte errors %0d, bit errors %0d", n_checks, byte_errs, bit_errs);
		if (byte_errs + bit_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- verilog.f
logic/spi_master_pkg.sv
logic/sync_fifo.sv
logic/spi_phase_gen.sv
logic/spi_cmd_capture.sv
logic/spi_bus_fsm.sv
logic/spi_rx_capture.sv
logic/spi_master_top.sv
verif/spi_flash_model.sv
verif/tb_spi_master.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - logic/spi_master_pkg.sv
  - logic/sync_fifo.sv
  - logic/spi_phase_gen.sv
  - logic/spi_cmd_capture.sv
  - logic/spi_bus_fsm.sv
  - logic/spi_rx_capture.sv
  - logic/spi_master_top.sv
  - target: test
    files:
      - verif/spi_flash_model.sv
      - verif/tb_spi_master.sv
